/* common/board_pkg.sv */
`default_nettype none

package board_pkg;

    // instruction word size
    localparam int word_width = 32;
    localparam int word_bytes = word_width / 8;

    // unified byte memory, 64 words
    localparam int mem_bytes  = 256;
    localparam int addr_width = 8;

    // first byte address fetched out of reset
    localparam logic [addr_width-1:0] start_addr = '0;

    // program image loaded into the fetch memory
    localparam string prog_file = "program.hex";

    // jump target is a word index, byte address is four times it
    localparam int word_idx_width = addr_width - 2;

    // instruction queue geometry
    localparam int queue_depth     = 4;
    localparam int queue_ptr_width = $clog2(queue_depth);
    localparam int queue_cnt_width = $clog2(queue_depth + 1);

    // one step per second on a 50 MHz board clock
    localparam int step_cycles_board = 50_000_000;

    // word layout, byte lanes in the 32-bit instruction
    // byte 3 opcode, byte 1 jump target, byte 0 immediate
    // byte 2 unused
    localparam int op_lsb     = 24;
    localparam int target_lsb = 8;
    localparam int imm_lsb    = 0;

    // opcodes in byte 3
    // anything else is a no-op, heartbeat only
    typedef enum logic [7:0] {
        op_show = 8'h01,
        op_add  = 8'h02,
        op_xor  = 8'h03,
        op_jump = 8'h04,
        op_halt = 8'h0F
    } opcode_t;

endpackage

`default_nettype wire

/* fetch/instr_fetch.sv */
`default_nettype none
`timescale 1ns/1ps

module instr_fetch (
    input  logic                             clk_in,
    input  logic                             KEY0,
    input  logic                             redirect,
    input  logic [board_pkg::addr_width-1:0] redirect_addr,
    output logic                             fetch_valid,
    output logic [board_pkg::word_width-1:0] fetch_word,
    input  logic                             fetch_ready
);
    import board_pkg::*;

    // unified byte memory, read only here
    logic [7:0] mem [0:mem_bytes-1];

    // byte address of the next word to load
    logic [addr_width-1:0] pc;

    // byte lanes of the word at pc
    logic [addr_width-1:0] addr_b1;
    logic [addr_width-1:0] addr_b2;
    logic [addr_width-1:0] addr_b3;
    logic [word_width-1:0] word_at_pc;

    // load a new word into the output register
    logic load_word;

    initial begin
        $readmemh(prog_file, mem);
    end

    // addresses stay addr_width wide so they wrap at mem_bytes
    assign addr_b1 = pc + addr_width'(1);
    assign addr_b2 = pc + addr_width'(2);
    assign addr_b3 = pc + addr_width'(3);

    // little endian, byte 0 at the lowest address
    assign word_at_pc = {mem[addr_b3], mem[addr_b2], mem[addr_b1], mem[pc]};

    // slot is free when empty or being taken this cycle
    // redirect wins and throws away whatever was on offer
    assign load_word = !redirect && (!fetch_valid || fetch_ready);

    // pc and valid flag
    always_ff @(posedge clk_in or negedge KEY0) begin
        if (!KEY0) begin
            pc          <= start_addr;
            fetch_valid <= 1'b0;
        end else if (redirect) begin
            // bubble of one cycle, next word loads from the new pc
            pc          <= redirect_addr;
            fetch_valid <= 1'b0;
        end else if (load_word) begin
            pc          <= pc + addr_width'(word_bytes);
            fetch_valid <= 1'b1;
        end
    end

    // offered word, held while back-pressured
    always_ff @(posedge clk_in) begin
        if (load_word) begin
            fetch_word <= word_at_pc;
        end
    end

endmodule

`default_nettype wire

/* design/instr_queue.sv */
`default_nettype none
`timescale 1ns/1ps

module instr_queue (
    input  logic                             clk_in,
    input  logic                             KEY0,
    input  logic                             flush,
    input  logic                             push_valid,
    input  logic [board_pkg::word_width-1:0] push_word,
    output logic                             push_ready,
    output logic                             pop_valid,
    output logic [board_pkg::word_width-1:0] pop_word,
    input  logic                             pop_ready
);
    import board_pkg::*;

    // circular word storage
    logic [word_width-1:0] slots [0:queue_depth-1];

    logic [queue_ptr_width-1:0] wr_ptr;
    logic [queue_ptr_width-1:0] rd_ptr;
    logic [queue_cnt_width-1:0] count;

    logic do_push;
    logic do_pop;

    // pointer step with wrap at queue_depth
    function automatic logic [queue_ptr_width-1:0] ptr_next(
        input logic [queue_ptr_width-1:0] ptr
    );
        if (ptr == queue_ptr_width'(queue_depth - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = ptr + 1'b1;
        end
    endfunction

    // ready drops only when full
    assign push_ready = (count != queue_cnt_width'(queue_depth));
    assign pop_valid  = (count != '0);
    assign pop_word   = slots[rd_ptr];

    assign do_push = push_valid && push_ready;
    assign do_pop  = pop_valid && pop_ready;

    // pointers and fill level
    always_ff @(posedge clk_in or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // flush beats any push in the same cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage write
    always_ff @(posedge clk_in) begin
        if (do_push && !flush) begin
            slots[wr_ptr] <= push_word;
        end
    end

endmodule

`default_nettype wire

/* execute/led_executor.sv */
`default_nettype none
`timescale 1ns/1ps

module led_executor #(
    parameter int step_cycles = board_pkg::step_cycles_board
) (
    input  logic                             clk_in,
    input  logic                             KEY0,
    input  logic                             instr_valid,
    input  logic [board_pkg::word_width-1:0] instr_word,
    output logic                             instr_ready,
    output logic                             redirect,
    output logic [board_pkg::addr_width-1:0] redirect_addr,
    output logic [7:0]                       ledg,
    output logic                             ledr0,
    output logic                             halted
);
    import board_pkg::*;

    // pace counter runs 0 .. step_cycles-1
    localparam int pace_width = (step_cycles > 1) ? $clog2(step_cycles) : 1;
    localparam logic [pace_width-1:0] pace_last = pace_width'(step_cycles - 1);

    logic [pace_width-1:0] pace_cnt;
    logic                  step;
    logic                  consume;

    // decoded fields
    opcode_t                   opcode;
    logic [7:0]                imm;
    logic [word_idx_width-1:0] target;

    // one-cycle step enable instead of a slow derived clock
    assign step = (pace_cnt == pace_last);

    // no take while the jump flush is in progress
    assign instr_ready = step && !halted && !redirect;
    assign consume     = instr_valid && instr_ready;

    assign opcode = opcode_t'(instr_word[op_lsb +: 8]);
    assign imm    = instr_word[imm_lsb +: 8];
    assign target = instr_word[target_lsb +: word_idx_width];

    // free running pace, not disturbed by jumps
    always_ff @(posedge clk_in or negedge KEY0) begin
        if (!KEY0) begin
            pace_cnt <= '0;
        end else if (step) begin
            pace_cnt <= '0;
        end else begin
            pace_cnt <= pace_cnt + 1'b1;
        end
    end

    // LED state, heartbeat, halt and redirect pulse
    always_ff @(posedge clk_in or negedge KEY0) begin
        if (!KEY0) begin
            ledg     <= 8'h00;
            ledr0    <= 1'b0;
            halted   <= 1'b0;
            redirect <= 1'b0;
        end else begin
            // redirect is a single cycle pulse
            redirect <= 1'b0;
            if (consume) begin
                // heartbeat on every consumed word
                ledr0 <= ~ledr0;
                case (opcode)
                    op_show: ledg     <= imm;
                    // 8-bit wraparound
                    op_add:  ledg     <= ledg + imm;
                    op_xor:  ledg     <= ledg ^ imm;
                    op_jump: redirect <= 1'b1;
                    // sticky until reset
                    op_halt: halted   <= 1'b1;
                    default: ledg     <= ledg;
                endcase
            end
        end
    end

    // jump target as a byte address, valid with redirect
    always_ff @(posedge clk_in) begin
        if (consume && opcode == op_jump) begin
            redirect_addr <= {target, 2'b00};
        end
    end

endmodule

`default_nettype wire

/* design/cpu_on_board.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_on_board #(
    parameter int step_cycles = board_pkg::step_cycles_board
) (
    input  logic       clk_in,
    input  logic       KEY0,
    output logic [7:0] ledg,
    output logic       ledr0,
    output logic       halted
);
    import board_pkg::*;

    // fetch to queue handshake
    logic                  fetch_valid;
    logic                  fetch_ready;
    logic [word_width-1:0] fetch_word;

    // queue to executor handshake
    logic                  instr_valid;
    logic                  instr_ready;
    logic [word_width-1:0] instr_word;

    // jump path back to fetch and queue
    logic                  redirect;
    logic [addr_width-1:0] redirect_addr;

    instr_fetch instr_fetch_inst (
        .clk_in        (clk_in),
        .KEY0          (KEY0),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .fetch_valid   (fetch_valid),
        .fetch_word    (fetch_word),
        .fetch_ready   (fetch_ready)
    );

    // same redirect pulse empties the queue
    instr_queue instr_queue_inst (
        .clk_in     (clk_in),
        .KEY0       (KEY0),
        .flush      (redirect),
        .push_valid (fetch_valid),
        .push_word  (fetch_word),
        .push_ready (fetch_ready),
        .pop_valid  (instr_valid),
        .pop_word   (instr_word),
        .pop_ready  (instr_ready)
    );

    led_executor #(
        .step_cycles (step_cycles)
    ) led_executor_inst (
        .clk_in        (clk_in),
        .KEY0          (KEY0),
        .instr_valid   (instr_valid),
        .instr_word    (instr_word),
        .instr_ready   (instr_ready),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .ledg          (ledg),
        .ledr0         (ledr0),
        .halted        (halted)
    );

endmodule

`default_nettype wire

/* bench/tb_cpu_on_board.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_cpu_on_board;

    // pace and clocking
    localparam int step_cycles  = 8;
    localparam int clk_period   = 40;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 3;
    // quiet time checked after the halt word
    localparam int hold_steps   = 4;
    // replay bound for the reference model
    localparam int max_replay   = 1024;

    logic       clk_in;
    logic       KEY0;
    logic [7:0] ledg;
    logic       ledr0;
    logic       halted;

    // own copy of the program image
    logic [7:0] prog_mem [0:255];

    // fixed seed, nothing random is drawn
    int seed = 56;

    int         cycle_cnt = 0;
    int         cycle_limit = 0;
    int         expected_total = 0;
    int         toggle_cnt = 0;
    int         last_toggle_cycle = 0;
    int         release_cycle = 0;
    logic       last_ledr0 = 1'b0;
    logic       halt_seen = 1'b0;
    logic [8:0] expected_state;
    logic [7:0] held_ledg;
    logic       held_ledr0;

    cpu_on_board #(
        .step_cycles (step_cycles)
    ) cpu_on_board_inst (
        .clk_in (clk_in),
        .KEY0   (KEY0),
        .ledg   (ledg),
        .ledr0  (ledr0),
        .halted (halted)
    );

    initial begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    // every failure ends here
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0d ns: %s is 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // registered outputs and handshake flags all low
    task automatic check_outputs_low(input bit with_fetch);
        check_value("ledg", 32'(ledg), 32'h0);
        check_value("ledr0", 32'(ledr0), 32'h0);
        check_value("halted", 32'(halted), 32'h0);
        check_value("redirect", 32'(cpu_on_board_inst.redirect), 32'h0);
        if (with_fetch) begin
            check_value("fetch_valid", 32'(cpu_on_board_inst.fetch_valid), 32'h0);
            check_value("instr_valid", 32'(cpu_on_board_inst.instr_valid), 32'h0);
        end
    endtask

    // replay the program for a number of consumed words
    // returns {halted, ledg}
    function automatic logic [8:0] model_after(input int steps);
        logic [7:0] pc;
        logic [7:0] led;
        logic       done;
        logic [7:0] op;
        logic [7:0] imm;
        logic [7:0] tgt;
        int         i;
        pc   = 8'h00;
        led  = 8'h00;
        done = 1'b0;
        for (i = 0; i < steps; i++) begin
            if (!done) begin
                // little endian word, opcode in the top byte
                op  = prog_mem[pc + 8'd3];
                tgt = prog_mem[pc + 8'd1];
                imm = prog_mem[pc];
                case (op)
                    8'h01:   led = imm;
                    // wraps at 8 bits
                    8'h02:   led = led + imm;
                    8'h03:   led = led ^ imm;
                    8'h0F:   done = 1'b1;
                    default: led = led;
                endcase
                // jump target is a word index
                if (op == 8'h04) begin
                    pc = {tgt[5:0], 2'b00};
                end else begin
                    pc = pc + 8'd4;
                end
            end
        end
        return {done, led};
    endfunction

    // number of words consumed up to and including the halt
    function automatic int count_to_halt();
        int         n;
        logic [8:0] state;
        for (n = 1; n <= max_replay; n++) begin
            state = model_after(n);
            if (state[8]) begin
                return n;
            end
        end
        return -1;
    endfunction

    // cycle counter and run limit
    always @(posedge clk_in) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            abort_run("Timeout: the program did not reach its halt word in time");
        end
    end

    // compare at every heartbeat toggle, sampled mid-cycle
    always @(negedge clk_in) begin
        if (KEY0 && ledr0 !== last_ledr0) begin
            toggle_cnt = toggle_cnt + 1;
            last_ledr0 = ledr0;
            if (toggle_cnt > expected_total) begin
                abort_run("Heartbeat toggled after the halt word was executed");
            end else begin
                expected_state = model_after(toggle_cnt);
                check_value("ledg", 32'(ledg), 32'(expected_state[7:0]));
                check_value("halted", 32'(halted), 32'(expected_state[8]));
                // one toggle per step since release, none lost
                check_value("toggle_count", 32'(toggle_cnt),
                            32'((cycle_cnt - release_cycle) / step_cycles));
                // steps stay evenly spaced, jumps included
                if (toggle_cnt > 1) begin
                    check_value("step_interval", 32'(cycle_cnt - last_toggle_cycle),
                                32'(step_cycles));
                end
                last_toggle_cycle = cycle_cnt;
                if (expected_state[8]) begin
                    halt_seen = 1'b1;
                end
            end
        end
    end

    initial begin
        KEY0 = 1'b0;
        $readmemh("bench/program.hex", prog_mem);
        expected_total = count_to_halt();
        if (expected_total < 0) begin
            abort_run("Program image never reaches a halt word");
        end
        cycle_limit = (expected_total + 10) * step_cycles * 2;

        // outputs low throughout reset
        repeat (reset_cycles) begin
            @(posedge clk_in);
            #(drive_delay);
            check_outputs_low(1'b1);
        end
        KEY0 = 1'b1;
        release_cycle = cycle_cnt;

        // fetch still idle on the first cycle out of reset
        @(negedge clk_in);
        check_outputs_low(1'b1);
        // no step yet, LEDs stay dark
        repeat (step_cycles - 2) begin
            @(negedge clk_in);
            check_outputs_low(1'b0);
        end

        wait (halt_seen == 1'b1);

        // frozen after halt
        held_ledg  = ledg;
        held_ledr0 = ledr0;
        repeat (hold_steps * step_cycles) begin
            @(negedge clk_in);
            check_value("ledg", 32'(ledg), 32'(held_ledg));
            check_value("ledr0", 32'(ledr0), 32'(held_ledr0));
            check_value("halted", 32'(halted), 32'h1);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/program.hex */
// one word per line, little endian bytes
// columns: imm, jump target word, unused, opcode
@00
5A 00 00 01 // w0 show 5a
30 00 00 02 // w1 add 30
90 00 00 02 // w2 add 90, wraps
FF 00 00 03 // w3 xor ff
77 00 00 00 // w4 no-op
00 0C 00 04 // w5 jump forward to w12
EE 00 00 01 // w6 skipped
55 00 00 03 // w7 skipped
11 00 00 02 // w8 skipped
3C 00 00 01 // w9 show 3c, backward target
7E 00 00 A5 // w10 no-op
00 14 00 04 // w11 jump forward to w20
0F 00 00 03 // w12 xor 0f
C8 00 00 02 // w13 add c8
00 09 00 04 // w14 jump backward to w9
99 00 00 01 // w15 skipped
42 00 00 03 // w16 skipped
// tail of the program at w20
@50
81 00 00 03 // w20 xor 81
10 00 00 10 // w21 no-op
FF 00 00 02 // w22 add ff
00 00 00 0F // w23 halt
00 00 00 01 // w24 never executed
FF 00 00 03 // w25 never executed

/* sources.f */
common/board_pkg.sv
fetch/instr_fetch.sv
design/instr_queue.sv
execute/led_executor.sv
design/cpu_on_board.sv
bench/tb_cpu_on_board.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sources.f --top-module tb_cpu_on_board || exit 1

# the fetch memory loads its image from the working directory
cp bench/program.hex program.hex || exit 1

out=$(./obj_dir/Vtb_cpu_on_board 2>&1)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
